// ==== Bender.yml ====
package:
  name: l1_req_subsystem

sources:
  - files:
      - l1_subsys_pkg.sv
      - hwpf_stride_engine.sv
      - hwpf_stride_unit.sv
      - req_arbiter.sv
      - l1_req_subsystem.sv
  - target: test
    files:
      - l1_req_subsystem_props.sv
      - tb_l1_req_subsystem.sv

// ==== hwpf_stride_engine.sv ====
// Stride prefetch engine; a snoop hit on the base block starts a run of nblocks loads
// Stride is unsigned and addresses wrap at the top of the address space
`timescale 1ns/10ps

module hwpf_stride_engine (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          base_set_i,
  input  l1_subsys_pkg::hwpf_base_t     base_i,
  output l1_subsys_pkg::hwpf_base_t     base_o,
  input  logic                          param_set_i,
  input  l1_subsys_pkg::hwpf_param_t    param_i,
  output l1_subsys_pkg::hwpf_param_t    param_o,
  input  logic                          throttle_set_i,
  input  l1_subsys_pkg::hwpf_throttle_t throttle_i,
  output l1_subsys_pkg::hwpf_throttle_t throttle_o,
  input  l1_subsys_pkg::snoop_t [1:0]   snoop_i,
  output logic                          req_valid_o,
  input  logic                          req_ready_i,
  output l1_subsys_pkg::addr_t          req_addr_o,
  output logic                          busy_o
);

  l1_subsys_pkg::hwpf_base_t     base_q;
  l1_subsys_pkg::hwpf_param_t    param_q;
  l1_subsys_pkg::hwpf_throttle_t throttle_q;
  l1_subsys_pkg::hwpf_state_e    state_q, state_d;
  l1_subsys_pkg::addr_t          addr_q, addr_d;
  l1_subsys_pkg::addr_t          addr_step;
  l1_subsys_pkg::nblk_t          left_q, left_d;
  l1_subsys_pkg::nwait_t         wait_q, wait_d;
  logic [1:0]                    hit;
  logic                          trigger;
  logic                          accept;
  logic                          last;

  for (genvar s = 0; s < 2; s++) begin : gen_match
    assign hit[s] = snoop_i[s].valid &&
        (snoop_i[s].addr[l1_subsys_pkg::ADDR_W-1:l1_subsys_pkg::BLOCK_OFFSET_W] ==
         base_q.base[l1_subsys_pkg::ADDR_W-1:l1_subsys_pkg::BLOCK_OFFSET_W]);
  end

  assign trigger = (|hit) && base_q.enable && (state_q == l1_subsys_pkg::IDLE) &&
                   (param_q.nblocks != '0);
  assign accept    = (state_q == l1_subsys_pkg::ISSUE) && req_ready_i;
  assign last      = accept && (left_q == l1_subsys_pkg::nblk_t'(1));
  assign addr_step = l1_subsys_pkg::addr_t'(param_q.stride);

  always_comb begin
    state_d = state_q;
    addr_d  = addr_q;
    left_d  = left_q;
    wait_d  = wait_q;
    unique case (state_q)
      l1_subsys_pkg::IDLE: begin
        if (trigger) begin
          state_d = l1_subsys_pkg::ISSUE;
          addr_d  = base_q.base + addr_step;
          left_d  = param_q.nblocks;
        end
      end
      l1_subsys_pkg::ISSUE: begin
        if (accept) begin
          addr_d = addr_q + addr_step;
          left_d = left_q - l1_subsys_pkg::nblk_t'(1);
          wait_d = throttle_q.nwait;
          if (last) begin
            state_d = l1_subsys_pkg::IDLE;
          end else if (throttle_q.nwait != '0) begin
            state_d = l1_subsys_pkg::WAIT;
          end
        end
      end
      l1_subsys_pkg::WAIT: begin
        wait_d = wait_q - l1_subsys_pkg::nwait_t'(1);
        // Last idle cycle, request again next cycle
        if (wait_q <= l1_subsys_pkg::nwait_t'(1)) begin
          state_d = l1_subsys_pkg::ISSUE;
        end
      end
      default: state_d = l1_subsys_pkg::IDLE;
    endcase
    // New base aborts any run in flight
    if (base_set_i) begin
      state_d = l1_subsys_pkg::IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= l1_subsys_pkg::IDLE;
      addr_q  <= '0;
      left_q  <= '0;
      wait_q  <= '0;
    end else begin
      state_q <= state_d;
      addr_q  <= addr_d;
      left_q  <= left_d;
      wait_q  <= wait_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      base_q     <= '0;
      param_q    <= '0;
      throttle_q <= '0;
    end else begin
      if (base_set_i) begin
        base_q <= base_i;
      end else if (last) begin
        // Last issued address is base + nblocks * stride
        base_q.base <= addr_q;
      end
      if (param_set_i) begin
        param_q <= param_i;
      end
      if (throttle_set_i) begin
        throttle_q <= throttle_i;
      end
    end
  end

  assign req_valid_o = (state_q == l1_subsys_pkg::ISSUE);
  assign req_addr_o  = addr_q;
  assign busy_o      = (state_q != l1_subsys_pkg::IDLE);
  assign base_o      = base_q;
  assign param_o     = param_q;
  assign throttle_o  = throttle_q;

endmodule

// ==== hwpf_stride_unit.sv ====
// Prefetch engines behind one requester port; lowest engine index wins
// An offered request keeps its engine until accepted
`timescale 1ns/10ps

module hwpf_stride_unit (
  input  logic                                                    clk_i,
  input  logic                                                    rst_ni,
  input  logic [l1_subsys_pkg::NUM_HWPF-1:0]                      base_set_i,
  input  l1_subsys_pkg::hwpf_base_t [l1_subsys_pkg::NUM_HWPF-1:0] base_i,
  output l1_subsys_pkg::hwpf_base_t [l1_subsys_pkg::NUM_HWPF-1:0] base_o,
  input  logic [l1_subsys_pkg::NUM_HWPF-1:0]                      param_set_i,
  input  l1_subsys_pkg::hwpf_param_t [l1_subsys_pkg::NUM_HWPF-1:0] param_i,
  output l1_subsys_pkg::hwpf_param_t [l1_subsys_pkg::NUM_HWPF-1:0] param_o,
  input  logic [l1_subsys_pkg::NUM_HWPF-1:0]                      throttle_set_i,
  input  l1_subsys_pkg::hwpf_throttle_t [l1_subsys_pkg::NUM_HWPF-1:0] throttle_i,
  output l1_subsys_pkg::hwpf_throttle_t [l1_subsys_pkg::NUM_HWPF-1:0] throttle_o,
  input  l1_subsys_pkg::snoop_t [1:0]                             snoop_i,
  output logic                                                    req_valid_o,
  input  logic                                                    req_ready_i,
  output l1_subsys_pkg::core_req_t                                req_o,
  output logic [l1_subsys_pkg::NUM_HWPF-1:0]                      status_o
);

  logic [l1_subsys_pkg::NUM_HWPF-1:0]                 eng_valid;
  logic [l1_subsys_pkg::NUM_HWPF-1:0]                 eng_ready;
  l1_subsys_pkg::addr_t [l1_subsys_pkg::NUM_HWPF-1:0] eng_addr;
  logic [l1_subsys_pkg::NUM_HWPF-1:0]                 prio_oh;
  logic [l1_subsys_pkg::NUM_HWPF-1:0]                 sel_oh;
  logic [l1_subsys_pkg::NUM_HWPF-1:0]                 sel_q;

  for (genvar e = 0; e < l1_subsys_pkg::NUM_HWPF; e++) begin : gen_engine
    hwpf_stride_engine i_hwpf_stride_engine (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .base_set_i     (base_set_i[e]),
      .base_i         (base_i[e]),
      .base_o         (base_o[e]),
      .param_set_i    (param_set_i[e]),
      .param_i        (param_i[e]),
      .param_o        (param_o[e]),
      .throttle_set_i (throttle_set_i[e]),
      .throttle_i     (throttle_i[e]),
      .throttle_o     (throttle_o[e]),
      .snoop_i        (snoop_i),
      .req_valid_o    (eng_valid[e]),
      .req_ready_i    (eng_ready[e]),
      .req_addr_o     (eng_addr[e]),
      .busy_o         (status_o[e])
    );
  end

  // Lowest set bit of the requesting engines
  assign prio_oh = eng_valid & ~(eng_valid - 1'b1);
  assign sel_oh  = (|(sel_q & eng_valid)) ? sel_q : prio_oh;

  assign req_valid_o = |eng_valid;
  assign eng_ready   = sel_oh & {l1_subsys_pkg::NUM_HWPF{req_ready_i}};

  always_comb begin
    req_o.addr     = '0;
    req_o.is_store = 1'b0;
    for (int i = 0; i < l1_subsys_pkg::NUM_HWPF; i++) begin
      if (sel_oh[i]) begin
        req_o.addr = eng_addr[i];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q <= '0;
    end else begin
      sel_q <= (req_valid_o && !req_ready_i) ? sel_oh : '0;
    end
  end

endmodule

// ==== l1_req_subsystem.sv ====
// L1 request subsystem: three core ports plus a stride prefetcher onto one memory port
// Responses carry no data, only a one-cycle pulse on the owning core port
`timescale 1ns/10ps

module l1_req_subsystem (
  input  logic                                                    clk_i,
  input  logic                                                    rst_ni,
  input  logic [l1_subsys_pkg::NUM_PORTS-1:0]                     core_req_valid_i,
  input  l1_subsys_pkg::core_req_t [l1_subsys_pkg::NUM_PORTS-1:0] core_req_i,
  output logic [l1_subsys_pkg::NUM_PORTS-1:0]                     core_req_ready_o,
  output logic [l1_subsys_pkg::NUM_PORTS-1:0]                     core_rsp_valid_o,
  output logic                                                    mem_req_valid_o,
  input  logic                                                    mem_req_ready_i,
  output l1_subsys_pkg::mem_req_t                                 mem_req_o,
  input  logic                                                    mem_rsp_valid_i,
  input  l1_subsys_pkg::mem_rsp_t                                 mem_rsp_i,
  input  logic [l1_subsys_pkg::NUM_HWPF-1:0]                      hwpf_base_set_i,
  input  l1_subsys_pkg::hwpf_base_t [l1_subsys_pkg::NUM_HWPF-1:0] hwpf_base_i,
  output l1_subsys_pkg::hwpf_base_t [l1_subsys_pkg::NUM_HWPF-1:0] hwpf_base_o,
  input  logic [l1_subsys_pkg::NUM_HWPF-1:0]                      hwpf_param_set_i,
  input  l1_subsys_pkg::hwpf_param_t [l1_subsys_pkg::NUM_HWPF-1:0] hwpf_param_i,
  output l1_subsys_pkg::hwpf_param_t [l1_subsys_pkg::NUM_HWPF-1:0] hwpf_param_o,
  input  logic [l1_subsys_pkg::NUM_HWPF-1:0]                      hwpf_throttle_set_i,
  input  l1_subsys_pkg::hwpf_throttle_t [l1_subsys_pkg::NUM_HWPF-1:0] hwpf_throttle_i,
  output l1_subsys_pkg::hwpf_throttle_t [l1_subsys_pkg::NUM_HWPF-1:0] hwpf_throttle_o,
  output logic [l1_subsys_pkg::NUM_HWPF-1:0]                      hwpf_status_o
);

  logic [l1_subsys_pkg::NUM_REQ-1:0]                     req_valid;
  logic [l1_subsys_pkg::NUM_REQ-1:0]                     req_ready;
  l1_subsys_pkg::core_req_t [l1_subsys_pkg::NUM_REQ-1:0] req;
  l1_subsys_pkg::snoop_t [1:0]                           snoop;

  // Core ports take the low source ids
  assign req_valid[l1_subsys_pkg::NUM_PORTS-1:0] = core_req_valid_i;
  assign req[l1_subsys_pkg::NUM_PORTS-1:0]       = core_req_i;
  assign core_req_ready_o = req_ready[l1_subsys_pkg::NUM_PORTS-1:0];

  // Snoop only accepted loads and stores
  assign snoop[0].valid = core_req_valid_i[l1_subsys_pkg::SNOOP_LOAD_PORT] &&
                          req_ready[l1_subsys_pkg::SNOOP_LOAD_PORT];
  assign snoop[0].addr  = core_req_i[l1_subsys_pkg::SNOOP_LOAD_PORT].addr;
  assign snoop[1].valid = core_req_valid_i[l1_subsys_pkg::SNOOP_STORE_PORT] &&
                          req_ready[l1_subsys_pkg::SNOOP_STORE_PORT];
  assign snoop[1].addr  = core_req_i[l1_subsys_pkg::SNOOP_STORE_PORT].addr;

  hwpf_stride_unit i_hwpf_stride_unit (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .base_set_i     (hwpf_base_set_i),
    .base_i         (hwpf_base_i),
    .base_o         (hwpf_base_o),
    .param_set_i    (hwpf_param_set_i),
    .param_i        (hwpf_param_i),
    .param_o        (hwpf_param_o),
    .throttle_set_i (hwpf_throttle_set_i),
    .throttle_i     (hwpf_throttle_i),
    .throttle_o     (hwpf_throttle_o),
    .snoop_i        (snoop),
    .req_valid_o    (req_valid[l1_subsys_pkg::HWPF_SID]),
    .req_ready_i    (req_ready[l1_subsys_pkg::HWPF_SID]),
    .req_o          (req[l1_subsys_pkg::HWPF_SID]),
    .status_o       (hwpf_status_o)
  );

  req_arbiter i_req_arbiter (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (req_valid),
    .req_i           (req),
    .req_ready_o     (req_ready),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_req_o       (mem_req_o),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_i       (mem_rsp_i),
    .rsp_valid_o     (core_rsp_valid_o)
  );

endmodule

// ==== l1_req_subsystem_props.sv ====
// Interface properties of the L1 request subsystem, bound to every instance
`timescale 1ns/10ps

module l1_req_subsystem_props (
  input logic                         clk_i,
  input logic                         rst_ni,
  input logic [2:0]                   core_req_valid_i,
  input logic [2:0]                   core_rsp_valid_o,
  input logic                         mem_req_valid_o,
  input logic                         mem_req_ready_i,
  input l1_subsys_pkg::mem_req_t      mem_req_o,
  input logic                         mem_rsp_valid_i,
  input logic [1:0]                   hwpf_status_o
);

  mem_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o))
    else $error("memory request changed while stalled");

  reset_quiet: assert property (@(posedge clk_i)
      $rose(rst_ni) |-> !mem_req_valid_o && core_req_valid_i == '0 &&
                        hwpf_status_o == '0 && core_rsp_valid_o == '0)
    else $error("valid or busy high right after reset");

  rsp_has_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
      |core_rsp_valid_o |-> $past(mem_rsp_valid_i))
    else $error("core response without a memory response");

endmodule

bind l1_req_subsystem l1_req_subsystem_props props_i (.*);

// ==== l1_subsys_pkg.sv ====
// Sizes, vector types, request structs and FSM encoding of the L1 request subsystem
// Source ids below NUM_PORTS are core ports; HWPF_SID is the prefetcher
package l1_subsys_pkg;

  localparam int unsigned NUM_PORTS        = 3;
  localparam int unsigned NUM_HWPF         = 2;
  localparam int unsigned NUM_REQ          = 4;
  localparam int unsigned HWPF_SID         = 3;
  localparam int unsigned SNOOP_LOAD_PORT  = 1;
  localparam int unsigned SNOOP_STORE_PORT = 2;
  localparam int unsigned ADDR_W           = 32;
  // 64-byte blocks
  localparam int unsigned BLOCK_OFFSET_W   = 6;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [1:0]        sid_t;
  typedef logic [15:0]       stride_t;
  typedef logic [3:0]        nblk_t;
  typedef logic [7:0]        nwait_t;

  typedef struct packed {
    addr_t addr;
    logic  is_store;
  } core_req_t;

  typedef struct packed {
    addr_t addr;
    logic  is_store;
    sid_t  sid;
  } mem_req_t;

  typedef struct packed {
    sid_t sid;
  } mem_rsp_t;

  typedef struct packed {
    logic  valid;
    addr_t addr;
  } snoop_t;

  typedef struct packed {
    addr_t base;
    logic  enable;
  } hwpf_base_t;

  typedef struct packed {
    stride_t stride;
    nblk_t   nblocks;
  } hwpf_param_t;

  typedef struct packed {
    nwait_t nwait;
  } hwpf_throttle_t;

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT
  } hwpf_state_e;

endpackage

// ==== req_arbiter.sv ====
// Fixed-priority arbiter, index 0 highest; grant held from first valid until accepted
// Responses for source ids at or above NUM_PORTS are dropped
`timescale 1ns/10ps

module req_arbiter (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  input  logic [l1_subsys_pkg::NUM_REQ-1:0]                     req_valid_i,
  input  l1_subsys_pkg::core_req_t [l1_subsys_pkg::NUM_REQ-1:0] req_i,
  output logic [l1_subsys_pkg::NUM_REQ-1:0]                     req_ready_o,
  output logic                                                  mem_req_valid_o,
  input  logic                                                  mem_req_ready_i,
  output l1_subsys_pkg::mem_req_t                               mem_req_o,
  input  logic                                                  mem_rsp_valid_i,
  input  l1_subsys_pkg::mem_rsp_t                               mem_rsp_i,
  output logic [l1_subsys_pkg::NUM_PORTS-1:0]                   rsp_valid_o
);

  l1_subsys_pkg::sid_t                prio_idx;
  l1_subsys_pkg::sid_t                gnt;
  l1_subsys_pkg::sid_t                gnt_q;
  logic                               lock_q;
  logic [l1_subsys_pkg::NUM_PORTS-1:0] rsp_valid_d;
  logic [l1_subsys_pkg::NUM_PORTS-1:0] rsp_valid_q;

  // Walk down so the lowest valid index is left
  always_comb begin
    prio_idx = '0;
    for (int i = l1_subsys_pkg::NUM_REQ - 1; i >= 0; i--) begin
      if (req_valid_i[i]) begin
        prio_idx = l1_subsys_pkg::sid_t'(i);
      end
    end
  end

  assign gnt = lock_q ? gnt_q : prio_idx;

  assign mem_req_valid_o    = |req_valid_i;
  assign mem_req_o.addr     = req_i[gnt].addr;
  assign mem_req_o.is_store = req_i[gnt].is_store;
  assign mem_req_o.sid      = gnt;

  always_comb begin
    req_ready_o      = '0;
    req_ready_o[gnt] = mem_req_ready_i;
  end

  // Back-pressure locks the current winner
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lock_q <= 1'b0;
      gnt_q  <= '0;
    end else begin
      lock_q <= mem_req_valid_o && !mem_req_ready_i;
      gnt_q  <= gnt;
    end
  end

  always_comb begin
    rsp_valid_d = '0;
    for (int p = 0; p < l1_subsys_pkg::NUM_PORTS; p++) begin
      rsp_valid_d[p] = mem_rsp_valid_i && (mem_rsp_i.sid == l1_subsys_pkg::sid_t'(p));
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= '0;
    end else begin
      rsp_valid_q <= rsp_valid_d;
    end
  end

  assign rsp_valid_o = rsp_valid_q;

endmodule

// ==== tb.f ====
l1_subsys_pkg.sv
hwpf_stride_engine.sv
hwpf_stride_unit.sv
req_arbiter.sv
l1_req_subsystem.sv
l1_req_subsystem_props.sv
tb_l1_req_subsystem.sv

// ==== tb_l1_req_subsystem.sv ====
// Random core traffic, memory model and prefetch model around the L1 request subsystem
// Engine bases are only rewritten while the engines are idle
`timescale 1ns/10ps

module tb_l1_req_subsystem;

  localparam int unsigned NUM_TXN = 300;
  localparam int unsigned NUM_DIRECTED = 40;

  logic clk_i;
  logic rst_ni;
  logic [2:0] core_req_valid_i;
  l1_subsys_pkg::core_req_t [2:0] core_req_i;
  logic [2:0] core_req_ready_o;
  logic [2:0] core_rsp_valid_o;
  logic mem_req_valid_o;
  logic mem_req_ready_i;
  l1_subsys_pkg::mem_req_t mem_req_o;
  logic mem_rsp_valid_i;
  l1_subsys_pkg::mem_rsp_t mem_rsp_i;
  logic [1:0] hwpf_base_set_i;
  logic [1:0] hwpf_param_set_i;
  logic [1:0] hwpf_throttle_set_i;
  l1_subsys_pkg::hwpf_base_t [1:0] hwpf_base_i;
  l1_subsys_pkg::hwpf_base_t [1:0] hwpf_base_o;
  l1_subsys_pkg::hwpf_param_t [1:0] hwpf_param_i;
  l1_subsys_pkg::hwpf_param_t [1:0] hwpf_param_o;
  l1_subsys_pkg::hwpf_throttle_t [1:0] hwpf_throttle_i;
  l1_subsys_pkg::hwpf_throttle_t [1:0] hwpf_throttle_o;
  logic [1:0] hwpf_status_o;

  // Reference model state
  l1_subsys_pkg::core_req_t exp_q[3][$];
  l1_subsys_pkg::addr_t pf_q[2][$];
  l1_subsys_pkg::hwpf_base_t m_base[2];
  l1_subsys_pkg::hwpf_param_t m_param[2];
  l1_subsys_pkg::hwpf_throttle_t m_thr[2];
  logic [1:0] m_busy;
  int m_runpos[2];
  int last_acc[2];
  l1_subsys_pkg::sid_t rsp_sid_q[$];
  int rsp_due_q[$];
  int last_due;
  int cyc;
  int issued;
  logic [2:0] pend;
  logic [2:0] got_acc;
  logic [2:0] rsp_exp;
  logic lock_tb;
  int lock_sid;
  logic traffic_on;
  logic ready_rand;
  logic spacing_on;

  l1_req_subsystem dut_i (.*);

  always #10 clk_i = ~clk_i;

  task automatic abort_run();
    $display("Test failures found");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (exp === act) else begin
      $display("Fail %s: expected %0h, actual %0h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic issue_req(input int p, input l1_subsys_pkg::addr_t addr);
    core_req_valid_i[p] = 1'b1;
    core_req_i[p].addr = addr;
    core_req_i[p].is_store = (p == 2);
    pend[p] = 1'b1;
    got_acc[p] = 1'b0;
    exp_q[p].push_back(core_req_i[p]);
    issued++;
  endtask

  task automatic set_cfg(input int e, input l1_subsys_pkg::addr_t base, input logic en,
                         input l1_subsys_pkg::stride_t st, input l1_subsys_pkg::nblk_t nb,
                         input l1_subsys_pkg::nwait_t nw);
    @(negedge clk_i);
    hwpf_base_set_i[e] = 1'b1;
    hwpf_param_set_i[e] = 1'b1;
    hwpf_throttle_set_i[e] = 1'b1;
    hwpf_base_i[e] = '{base: base, enable: en};
    hwpf_param_i[e] = '{stride: st, nblocks: nb};
    hwpf_throttle_i[e] = '{nwait: nw};
    @(negedge clk_i);
    hwpf_base_set_i = '0;
    hwpf_param_set_i = '0;
    hwpf_throttle_set_i = '0;
    m_base[e] = hwpf_base_i[e];
    m_param[e] = hwpf_param_i[e];
    m_thr[e] = hwpf_throttle_i[e];
    check_value("base_readback", m_base[e], hwpf_base_o[e]);
    check_value("param_readback", m_param[e], hwpf_param_o[e]);
    check_value("throttle_readback", m_thr[e], hwpf_throttle_o[e]);
  endtask

  task automatic wait_idle();
    while (pend != '0 || m_busy != '0 || rsp_sid_q.size() != 0 || mem_req_valid_o ||
           exp_q[0].size() + exp_q[1].size() + exp_q[2].size() != 0) begin
      @(negedge clk_i);
    end
    // Let the last response pulse reach its core port
    repeat (2) @(negedge clk_i);
  endtask

  // Requesters and memory model, driven on the falling edge
  always @(negedge clk_i) begin
    int pick;
    l1_subsys_pkg::addr_t addr;
    if (rst_ni) begin
      mem_req_ready_i = ready_rand ? ($urandom % 10 < 7) : 1'b1;
      for (int p = 0; p < 3; p++) begin
        if (pend[p] && got_acc[p]) begin
          core_req_valid_i[p] = 1'b0;
          pend[p] = 1'b0;
        end
        if (!pend[p] && traffic_on && issued < NUM_TXN && $urandom % 3 == 0) begin
          pick = $urandom % 4;
          addr = $urandom;
          if (pick < 2) begin
            addr = {m_base[pick].base[31:6], addr[5:0]};
          end
          issue_req(p, addr);
        end
      end
      if (rsp_due_q.size() != 0 && rsp_due_q[0] <= cyc) begin
        mem_rsp_valid_i = 1'b1;
        mem_rsp_i.sid = rsp_sid_q.pop_front();
        void'(rsp_due_q.pop_front());
      end else begin
        mem_rsp_valid_i = 1'b0;
      end
    end
  end

  // Monitor: compares the DUT with the model at each rising edge
  always @(posedge clk_i) begin
    logic [1:0] trig;
    logic [2:0] exp_acc;
    int hit_e;
    int due;
    if (!rst_ni) begin
      rsp_exp = '0;
      lock_tb = 1'b0;
    end else begin
      cyc++;
      check_value("rsp_route", rsp_exp, core_rsp_valid_o);
      for (int e = 0; e < 2; e++) begin
        check_value("hwpf_status", m_busy[e], hwpf_status_o[e]);
        check_value("base_readback", m_base[e], hwpf_base_o[e]);
      end
      rsp_exp = '0;
      if (mem_rsp_valid_i && mem_rsp_i.sid < l1_subsys_pkg::NUM_PORTS) begin
        rsp_exp[mem_rsp_i.sid] = 1'b1;
      end
      if (mem_req_valid_o && !lock_tb) begin
        lock_sid = l1_subsys_pkg::HWPF_SID;
        for (int p = 2; p >= 0; p--) begin
          if (core_req_valid_i[p]) lock_sid = p;
        end
      end
      // Only the locked core port sees ready
      for (int p = 0; p < 3; p++) begin
        exp_acc[p] = core_req_valid_i[p] && mem_req_ready_i && (lock_sid == p);
      end
      check_value("core_accept", exp_acc, core_req_valid_i & core_req_ready_o);
      // Snoops of accepted loads and stores start runs
      trig = '0;
      for (int p = 0; p < 3; p++) begin
        if (core_req_valid_i[p] && core_req_ready_o[p]) begin
          got_acc[p] = 1'b1;
          for (int e = 0; e < 2; e++) begin
            if (p != 0 && core_req_i[p].addr[31:6] == m_base[e].base[31:6] &&
                m_base[e].enable && !m_busy[e] && m_param[e].nblocks != 0) begin
              trig[e] = 1'b1;
            end
          end
        end
      end
      for (int e = 0; e < 2; e++) begin
        if (trig[e]) begin
          m_busy[e] = 1'b1;
          m_runpos[e] = 0;
          for (int k = 1; k <= m_param[e].nblocks; k++) begin
            pf_q[e].push_back(m_base[e].base + k * m_param[e].stride);
          end
        end
      end
      if (mem_req_valid_o && mem_req_ready_i) begin
        check_value("grant_priority", lock_sid, mem_req_o.sid);
        // Memory answers every request, prefetches included
        due = cyc + 1 + $urandom % 6;
        if (due <= last_due) due = last_due + 1;
        last_due = due;
        rsp_sid_q.push_back(mem_req_o.sid);
        rsp_due_q.push_back(due);
        if (mem_req_o.sid < l1_subsys_pkg::NUM_PORTS) begin
          assert (exp_q[mem_req_o.sid].size() != 0) else begin
            $display("Memory request on port %0d that the port never issued", mem_req_o.sid);
            abort_run();
          end
          check_value("port_order", exp_q[mem_req_o.sid].pop_front(),
                      {mem_req_o.addr, mem_req_o.is_store});
        end else begin
          check_value("prefetch_is_store", 0, mem_req_o.is_store);
          hit_e = -1;
          for (int e = 1; e >= 0; e--) begin
            if (pf_q[e].size() != 0 && pf_q[e][0] == mem_req_o.addr) hit_e = e;
          end
          assert (hit_e >= 0) else begin
            $display("Prefetch request to %h matches no active run", mem_req_o.addr);
            abort_run();
          end
          void'(pf_q[hit_e].pop_front());
          if (spacing_on && m_runpos[hit_e] > 0) begin
            check_value("throttle_spacing", m_thr[hit_e].nwait + 1, cyc - last_acc[hit_e]);
          end
          last_acc[hit_e] = cyc;
          m_runpos[hit_e]++;
          if (pf_q[hit_e].size() == 0) begin
            m_busy[hit_e] = 1'b0;
            m_base[hit_e].base = m_base[hit_e].base +
                                 m_param[hit_e].nblocks * m_param[hit_e].stride;
          end
        end
      end
      lock_tb = mem_req_valid_o && !mem_req_ready_i;
    end
  end

  initial begin
    #((NUM_TXN + NUM_DIRECTED) * 40 * 20);
    $display("Timeout: the run did not finish within its cycle bound");
    abort_run();
  end

  initial begin
    void'($urandom(32'h0fd4cf49));
    clk_i = 1'b0;
    rst_ni = 1'b0;
    core_req_valid_i = '0;
    core_req_i = '0;
    mem_req_ready_i = 1'b0;
    mem_rsp_valid_i = 1'b0;
    mem_rsp_i = '0;
    hwpf_base_set_i = '0;
    hwpf_param_set_i = '0;
    hwpf_throttle_set_i = '0;
    hwpf_base_i = '0;
    hwpf_param_i = '0;
    hwpf_throttle_i = '0;
    m_base = '{default: '0};
    m_param = '{default: '0};
    m_thr = '{default: '0};
    m_busy = '0;
    cyc = 0;
    issued = 0;
    last_due = 0;
    pend = '0;
    got_acc = '0;
    traffic_on = 1'b0;
    ready_rand = 1'b0;
    spacing_on = 1'b0;
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    repeat (2) @(negedge clk_i);
    // Read-back of random values with the engines disabled
    for (int i = 0; i < 4; i++) begin
      for (int e = 0; e < 2; e++) begin
        set_cfg(e, $urandom, 1'b0, $urandom, $urandom, $urandom);
      end
    end
    // One run per engine with memory always ready
    spacing_on = 1'b1;
    for (int e = 0; e < 2; e++) begin
      set_cfg(e, 32'h1000_0000 + e * 32'h10_0000, 1'b1, 16'd64 * (e + 1), 3 + e, 2 * e + 1);
      set_cfg(1 - e, 32'h3000_0000, 1'b0, 16'd64, 4'd2, 8'd0);
      @(negedge clk_i);
      issue_req(1, m_base[e].base + 5);
      wait_idle();
    end
    spacing_on = 1'b0;
    // Port 0, a foreign block and a disabled engine start nothing
    @(negedge clk_i);
    issue_req(0, m_base[1].base);
    wait_idle();
    issue_req(1, m_base[1].base + 32'h40);
    wait_idle();
    issue_req(2, m_base[0].base);
    repeat (20) @(negedge clk_i);
    wait_idle();
    // Random traffic with back-pressure
    for (int e = 0; e < 2; e++) begin
      set_cfg(e, 32'h2000_0000 + e * 32'h0100_0000 + ($urandom % 64) * 64, 1'b1,
              16'd64 * ($urandom % 8 + 1), $urandom % 8 + 1, $urandom % 6);
    end
    issued = 0;
    ready_rand = 1'b1;
    traffic_on = 1'b1;
    while (issued < NUM_TXN) @(negedge clk_i);
    traffic_on = 1'b0;
    wait_idle();
    $display("All tests passed!");
    $finish;
  end

endmodule
